/* build.f */
+incdir+testbench
design/mem_parity_pkg.sv
design/parity_ctrl.sv
design/mem_data_xcvr.sv
design/parity_check_stage.sv
design/error_latch.sv
design/mem_data_top.sv
testbench/tb_mem_data.sv

/* testbench/tb_mem_data_model.svh */
/*
  Reference model of the parity slice, included inside the testbench top.
  advance_model runs once per rising edge after reset, push_read per read.
*/
`ifndef TB_MEM_DATA_MODEL_SVH
`define TB_MEM_DATA_MODEL_SVH

typedef struct {
  int                        due;   // Edge after which rd_valid shows it
  mem_parity_pkg::mem_word_t word;  // Word as driven, faults included
  logic                      ecc;
} exp_read_t;

exp_read_t                 rd_q[$];              // Reads in flight
int                        edge_cnt     = 0;     // Edges since reset release
logic                      m_dis        = 1'b0;  // Disable bit as held by the DUT
logic                      m_clr        = 1'b0;  // Clear pulse
logic                      exp_wr_valid = 1'b0;
mem_parity_pkg::mem_word_t exp_wr_mem;
logic                      exp_rd_valid = 1'b0;
mem_parity_pkg::lbd_t      exp_rd_data;
logic                      exp_lo_err   = 1'b0;
logic                      exp_hi_err   = 1'b0;
logic                      lo_stk       = 1'b0;  // Sticky lane errors
logic                      hi_stk       = 1'b0;
logic                      perr         = 1'b0;  // Drives lperr_n and led
int                        exp_count    = 0;

// Odd parity from the count of ones
function automatic logic lane_parity(input logic [7:0] b);
  return ($countones(b) % 2) == 0;
endfunction

// Memory word with correct parity above each lane
function automatic mem_parity_pkg::mem_word_t encode_word(input mem_parity_pkg::lbd_t d);
  mem_parity_pkg::mem_word_t w;
  w.data_lo = d[7:0];
  w.data_hi = d[15:8];
  w.par_lo  = lane_parity(d[7:0]);
  w.par_hi  = lane_parity(d[15:8]);
  return w;
endfunction

// Read driven in this cycle, result two edges on
task automatic push_read(input mem_parity_pkg::mem_word_t w, input logic ecc);
  exp_read_t e;
  e.due  = edge_cnt + 2;
  e.word = w;
  e.ecc  = ecc;
  rd_q.push_back(e);
endtask

// One rising edge, inputs as they stood before it
task automatic advance_model(input logic wr_s, input mem_parity_pkg::lbd_t wr_d,
                             input logic c_s, input mem_parity_pkg::lbd_t c_d);
  logic      any;
  int        base;
  exp_read_t e;
  edge_cnt++;
  // Sticky state from the check result held before this edge
  any = exp_rd_valid && (exp_lo_err || exp_hi_err);
  if (m_clr) begin
    lo_stk = 1'b0;
    hi_stk = 1'b0;
    perr   = 1'b0;
  end
  if (exp_rd_valid && exp_lo_err) lo_stk = 1'b1;  // Error beats clear
  if (exp_rd_valid && exp_hi_err) hi_stk = 1'b1;
  if (any) perr = 1'b1;
  base      = m_clr ? 0 : exp_count;
  exp_count = (any && base < (2 ** mem_parity_pkg::ERR_CNT_W) - 1) ? base + 1 : base;
  // Check result, disable still at its old value
  exp_rd_valid = 1'b0;
  exp_lo_err   = 1'b0;
  exp_hi_err   = 1'b0;
  if (rd_q.size() != 0 && rd_q[0].due == edge_cnt) begin
    e            = rd_q.pop_front();
    exp_rd_valid = 1'b1;
    exp_rd_data  = {e.word.data_hi, e.word.data_lo};
    exp_lo_err   = !e.ecc && !m_dis && (lane_parity(e.word.data_lo) != e.word.par_lo);
    exp_hi_err   = !e.ecc && !m_dis && (lane_parity(e.word.data_hi) != e.word.par_hi);
  end
  exp_wr_valid = wr_s;  // Write path, one edge
  if (wr_s) exp_wr_mem = encode_word(wr_d);
  // Control register, clear writes back to back merge
  m_clr = c_s && c_d[mem_parity_pkg::CTRL_CLR_BIT] && !m_clr;
  if (c_s) m_dis = c_d[mem_parity_pkg::CTRL_DIS_BIT];
endtask

`endif

/* testbench/tb_mem_data.sv */
/*
  Testbench for the memory data and parity slice. Random write, read and
  control traffic; every output is compared each cycle with the model.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_mem_data;

  localparam int PHASES     = 6;
  localparam int PHASE_CYC  = 300;  // Random phase length
  localparam int SAT_CYC    = 400;  // Enough faulty reads to saturate
  localparam int EXTRA_CYC  = 20;   // Drain and control per phase
  localparam int TOTAL_CYC  = SAT_CYC + PHASES * PHASE_CYC + (PHASES + 3) * EXTRA_CYC + 20;
  localparam int TIMEOUT_NS = TOTAL_CYC * 4 + 2000;

  logic                          clk = 1'b0;
  logic                          arst_n;
  logic                          wr_strobe;
  mem_parity_pkg::lbd_t          wr_data;
  logic                          wr_valid;
  mem_parity_pkg::mem_word_t     wr_mem;
  logic                          rd_strobe;
  mem_parity_pkg::mem_word_t     rd_mem;
  logic                          ecc_req;
  logic                          rd_valid;
  mem_parity_pkg::lbd_t          rd_data;
  logic                          lo_err;
  logic                          hi_err;
  logic                          ctrl_strobe;
  mem_parity_pkg::lbd_t          ctrl_data;
  logic                          lerr_n;
  logic                          lperr_n;
  logic                          led;
  logic [mem_parity_pkg::ERR_CNT_W-1:0] err_count;
  int                            errors   = 0;
  int                            n_reads  = 0;
  int                            n_writes = 0;

  `include "tb_mem_data_model.svh"

  always #2 clk = ~clk;  // 4 ns period

  mem_data_top dut0 (
    .clk (clk), .arst_n (arst_n),
    .wr_strobe (wr_strobe), .wr_data (wr_data), .wr_valid (wr_valid), .wr_mem (wr_mem),
    .rd_strobe (rd_strobe), .rd_mem (rd_mem), .ecc_req (ecc_req),
    .rd_valid (rd_valid), .rd_data (rd_data), .lo_err (lo_err), .hi_err (hi_err),
    .ctrl_strobe (ctrl_strobe), .ctrl_data (ctrl_data),
    .lerr_n (lerr_n), .lperr_n (lperr_n), .led (led), .err_count (err_count)
  );

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("** Error: %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic compare_outputs();
    check_value("wr_valid", exp_wr_valid, wr_valid);
    if (exp_wr_valid) check_value("wr_mem", exp_wr_mem, wr_mem);
    check_value("rd_valid", exp_rd_valid, rd_valid);
    if (exp_rd_valid) check_value("rd_data", exp_rd_data, rd_data);
    check_value("lo_err", exp_lo_err, lo_err);
    check_value("hi_err", exp_hi_err, hi_err);
    check_value("lerr_n", !(lo_stk || hi_stk), lerr_n);
    check_value("lperr_n", !perr, lperr_n);
    check_value("led", perr, led);
    check_value("err_count", exp_count, err_count);
  endtask

  // Edge, model, then compare once outputs settle
  task automatic next_cycle();
    @(posedge clk);
    advance_model(wr_strobe, wr_data, ctrl_strobe, ctrl_data);
    #1;
    compare_outputs();
  endtask

  task automatic drive_idle();
    wr_strobe   = 1'b0;
    rd_strobe   = 1'b0;
    ctrl_strobe = 1'b0;
    ecc_req     = 1'($urandom);
    wr_data     = mem_parity_pkg::lbd_t'($urandom);  // Junk on idle buses
    rd_mem      = mem_parity_pkg::mem_word_t'($urandom);
    ctrl_data   = mem_parity_pkg::lbd_t'($urandom);
  endtask

  task automatic drive_read(input int fault_pct, input int ecc_pct);
    mem_parity_pkg::mem_word_t w;
    w = encode_word(mem_parity_pkg::lbd_t'($urandom));
    if ($urandom_range(99) < fault_pct) w.par_lo = ~w.par_lo;  // Lane faults
    if ($urandom_range(99) < fault_pct) w.par_hi = ~w.par_hi;
    rd_strobe = 1'b1;
    rd_mem    = w;
    ecc_req   = ($urandom_range(99) < ecc_pct);
    push_read(w, ecc_req);
    n_reads++;
  endtask

  task automatic run_phase(input int n, input int rd_pct, input int fault_pct, input int ecc_pct);
    int op;
    for (int i = 0; i < n; i++) begin
      next_cycle();
      drive_idle();
      op = $urandom_range(99);
      if (op < rd_pct) begin
        drive_read(fault_pct, ecc_pct);
      end else if (op < rd_pct + (100 - rd_pct) / 2) begin
        wr_strobe = 1'b1;
        wr_data   = mem_parity_pkg::lbd_t'($urandom);
        n_writes++;
      end
    end
  endtask

  // Empty the read pipeline, then let the sticky stage settle
  task automatic drain_pipeline();
    next_cycle();
    drive_idle();
    while (rd_q.size() != 0) next_cycle();
    repeat (2) next_cycle();
  endtask

  task automatic write_control(input logic dis, input logic clr);
    next_cycle();
    drive_idle();
    ctrl_strobe = 1'b1;
    ctrl_data[mem_parity_pkg::CTRL_DIS_BIT] = dis;
    ctrl_data[mem_parity_pkg::CTRL_CLR_BIT] = clr;
    next_cycle();
    drive_idle();
    repeat (2) next_cycle();  // Sticky state clear by now
  endtask

  // Faulty read lands on the sticky stage with the clear pulse
  task automatic clear_collision_test();
    mem_parity_pkg::mem_word_t w;
    write_control(1'b0, 1'b0);
    next_cycle();
    drive_idle();
    w        = encode_word(mem_parity_pkg::lbd_t'($urandom));
    w.par_lo = ~w.par_lo;
    rd_strobe = 1'b1;
    rd_mem    = w;
    ecc_req   = 1'b0;
    push_read(w, 1'b0);
    n_reads++;
    next_cycle();
    drive_idle();
    ctrl_strobe = 1'b1;
    ctrl_data[mem_parity_pkg::CTRL_DIS_BIT] = 1'b0;
    ctrl_data[mem_parity_pkg::CTRL_CLR_BIT] = 1'b1;
    drain_pipeline();
    assert (err_count == 1 && !lerr_n && led) else begin
      errors++;
      $display("Clear command wiped out a parity error that arrived in the same cycle");
    end
  endtask

  initial begin
    void'($urandom(32'he25a87bb));
    arst_n = 1'b0;
    drive_idle();
    repeat (10) @(posedge clk);
    #1 arst_n = 1'b1;
    compare_outputs();  // Reset state
    // Saturation run, checking on and counter cleared
    write_control(1'b0, 1'b1);
    run_phase(SAT_CYC, 90, 80, 0);
    drain_pipeline();
    assert (err_count == 8'hff) else begin
      errors++;
      $display("Error counter did not saturate after a long run of faulty reads");
    end
    // First phase clears the saturated state, a later one turns checking off
    for (int p = 0; p < PHASES; p++) begin
      write_control((p == 2) || ($urandom_range(99) < 30),
                    (p == 0) || ($urandom_range(2) == 0));
      run_phase(PHASE_CYC, $urandom_range(30, 60), $urandom_range(5, 40),
                $urandom_range(0, 30));
      drain_pipeline();
    end
    clear_collision_test();
    $display("Summary: %0d errors over %0d reads and %0d writes", errors, n_reads, n_writes);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog sized from the phase lengths
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* design/mem_data_top.sv */
/*
  Data and parity transceiver slice of the memory board. Write path encodes
  parity in one cycle, read path checks and latches errors over three stages.
*/
`timescale 1ns/1ps
`default_nettype none

module mem_data_top (
  input  wire                       clk,
  input  wire                       arst_n,
  // Write side
  input  wire                       wr_strobe,
  input  wire mem_parity_pkg::lbd_t wr_data,
  output logic                      wr_valid,
  output mem_parity_pkg::mem_word_t wr_mem,
  // Read side
  input  wire                       rd_strobe,
  input  wire mem_parity_pkg::mem_word_t rd_mem,
  input  wire                       ecc_req,
  output logic                      rd_valid,
  output mem_parity_pkg::lbd_t      rd_data,
  output logic                      lo_err,
  output logic                      hi_err,
  // Control side
  input  wire                       ctrl_strobe,
  input  wire mem_parity_pkg::lbd_t ctrl_data,
  // Status
  output logic                      lerr_n,
  output logic                      lperr_n,
  output logic                      led,
  output logic [mem_parity_pkg::ERR_CNT_W-1:0] err_count
);

  mem_parity_pkg::rd_cap_t     rd_cap;      // Stage 1 to stage 2
  mem_parity_pkg::chk_result_t chk;         // Stage 2 to stage 3 and ports
  logic                        parity_dis;
  logic                        clr_pulse;

  parity_ctrl u_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .ctrl_strobe (ctrl_strobe),
    .ctrl_data   (ctrl_data),
    .parity_dis  (parity_dis),
    .clr_pulse   (clr_pulse)
  );

  mem_data_xcvr u_xcvr (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_strobe (wr_strobe),
    .wr_data   (wr_data),
    .wr_valid  (wr_valid),
    .wr_mem    (wr_mem),
    .rd_strobe (rd_strobe),
    .rd_mem    (rd_mem),
    .ecc_req   (ecc_req),
    .rd_cap    (rd_cap)
  );

  parity_check_stage u_check (
    .clk        (clk),
    .arst_n     (arst_n),
    .rd_cap     (rd_cap),
    .parity_dis (parity_dis),
    .chk        (chk)
  );

  error_latch u_latch (
    .clk       (clk),
    .arst_n    (arst_n),
    .chk       (chk),
    .clr_pulse (clr_pulse),
    .lerr_n    (lerr_n),
    .lperr_n   (lperr_n),
    .led       (led),
    .err_count (err_count)
  );

  // Check result straight out to the local bus
  assign rd_valid = chk.valid;
  assign rd_data  = chk.data;
  assign lo_err   = chk.lo_err;
  assign hi_err   = chk.hi_err;

endmodule

`default_nettype wire

/* design/error_latch.sv */
/*
  Pipeline stage 3. Sticky lane errors, local error, red parity LED and a
  saturating count of faulty reads, all cleared by the control register.
*/
`timescale 1ns/1ps
`default_nettype none

module error_latch (
  input  wire                             clk,
  input  wire                             arst_n,
  input  wire mem_parity_pkg::chk_result_t chk,
  input  wire                             clr_pulse,  // From control register
  output logic                            lerr_n,     // Local error, low active
  output logic                            lperr_n,    // Local parity error
  output logic                            led,        // Red parity LED
  output logic [mem_parity_pkg::ERR_CNT_W-1:0] err_count
);

  localparam int CW = mem_parity_pkg::ERR_CNT_W;

  logic          any_err;   // Faulty read this cycle
  logic          lo_stk;    // Sticky low lane error
  logic          hi_stk;    // Sticky high lane error
  logic          perr_q;    // Parity error seen since clear
  logic [CW-1:0] cnt_base;  // Count after a pending clear
  logic [CW-1:0] cnt_q;

  assign any_err = chk.valid & (chk.lo_err | chk.hi_err);

  // Clear applies first, a new error in the same cycle overrides it
  assign cnt_base = clr_pulse ? '0 : cnt_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lo_stk <= 1'b0;
      hi_stk <= 1'b0;
      perr_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      if (clr_pulse) begin
        lo_stk <= 1'b0;
        hi_stk <= 1'b0;
        perr_q <= 1'b0;
      end
      if (chk.valid && chk.lo_err) lo_stk <= 1'b1;
      if (chk.valid && chk.hi_err) hi_stk <= 1'b1;
      if (any_err) perr_q <= 1'b1;  // Latched on first fault
      // Saturate at all ones
      if (any_err && (cnt_base != '1)) begin
        cnt_q <= cnt_base + 1'b1;
      end else begin
        cnt_q <= cnt_base;
      end
    end
  end

  assign lerr_n    = ~(lo_stk | hi_stk);
  assign lperr_n   = ~perr_q;
  assign led       = perr_q;  // Lit while parity error held
  assign err_count = cnt_q;

  // Only a clear can lower the count
  a_cnt_mono : assert property (
    @(posedge clk) disable iff (!arst_n)
    !clr_pulse |=> (err_count >= $past(err_count))
  ) else $error("err_count decreased without clr_pulse");

  // Stage 2 must never flag a lane fault on an empty slot
  a_err_valid : assert property (
    @(posedge clk) disable iff (!arst_n)
    (chk.lo_err || chk.hi_err) |-> chk.valid
  ) else $error("lane error without valid read");

endmodule

`default_nettype wire

/* design/parity_check_stage.sv */
/*
  Pipeline stage 2. Recomputes odd parity on both lanes of a captured read
  and flags lane faults unless the read belongs to ECC or checking is off.
*/
`timescale 1ns/1ps
`default_nettype none

module parity_check_stage (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire mem_parity_pkg::rd_cap_t rd_cap,
  input  wire                         parity_dis,  // Sampled here
  output mem_parity_pkg::chk_result_t chk
);

  logic                 chk_en;   // Lane faults may be reported
  logic                 lo_bad;   // Low lane parity mismatch
  logic                 hi_bad;   // High lane parity mismatch
  mem_parity_pkg::lbd_t data_q;
  logic                 lo_err_q;
  logic                 hi_err_q;
  logic                 valid_q;

  // Only plain reads with checking on
  assign chk_en = rd_cap.valid & ~rd_cap.ecc & ~parity_dis;

  assign lo_bad = mem_parity_pkg::odd_parity(rd_cap.word.data_lo) != rd_cap.word.par_lo;
  assign hi_bad = mem_parity_pkg::odd_parity(rd_cap.word.data_hi) != rd_cap.word.par_hi;

  // Control flags
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q  <= 1'b0;
      lo_err_q <= 1'b0;
      hi_err_q <= 1'b0;
    end else begin
      valid_q  <= rd_cap.valid;
      lo_err_q <= chk_en & lo_bad;
      hi_err_q <= chk_en & hi_bad;
    end
  end

  // Data with parity bits stripped
  always_ff @(posedge clk) begin
    if (rd_cap.valid) begin
      data_q <= {rd_cap.word.data_hi, rd_cap.word.data_lo};
    end
  end

  assign chk = '{data: data_q, lo_err: lo_err_q, hi_err: hi_err_q, valid: valid_q};

endmodule

`default_nettype wire

/* design/mem_data_xcvr.sv */
/*
  Pipeline stage 1. Encodes odd parity per lane on the write path and
  registers read words with their ECC flag, like a clocked bus transceiver.
*/
`timescale 1ns/1ps
`default_nettype none

module mem_data_xcvr (
  input  wire                       clk,
  input  wire                       arst_n,
  // Write side, local bus to memory
  input  wire                       wr_strobe,
  input  wire mem_parity_pkg::lbd_t wr_data,
  output logic                      wr_valid,
  output mem_parity_pkg::mem_word_t wr_mem,
  // Read side, memory to checker
  input  wire                       rd_strobe,
  input  wire mem_parity_pkg::mem_word_t rd_mem,
  input  wire                       ecc_req,  // ECC owns this read
  output mem_parity_pkg::rd_cap_t   rd_cap
);

  localparam int BW = mem_parity_pkg::BYTE_W;

  logic [BW-1:0]                    wr_lo;      // Low lane of write data
  logic [BW-1:0]                    wr_hi;      // High lane of write data
  logic [mem_parity_pkg::MEM_W-1:0] wr_enc;     // Encoded memory word
  mem_parity_pkg::mem_word_t        wr_mem_q;
  mem_parity_pkg::mem_word_t        rd_word_q;  // Captured memory word
  logic                             rd_ecc_q;
  logic                             rd_valid_q;

  assign wr_lo = wr_data[0 +: BW];
  assign wr_hi = wr_data[BW +: BW];

  // Parity sits above each lane
  assign wr_enc = {mem_parity_pkg::odd_parity(wr_hi), wr_hi,
                   mem_parity_pkg::odd_parity(wr_lo), wr_lo};

  // Write and read valid flags
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_valid   <= 1'b0;
      rd_valid_q <= 1'b0;
    end else begin
      wr_valid   <= wr_strobe;  // Exactly one cycle behind the strobe
      rd_valid_q <= rd_strobe;
    end
  end

  // Payload registers, loaded only on their strobe
  always_ff @(posedge clk) begin
    if (wr_strobe) begin
      wr_mem_q <= mem_parity_pkg::mem_word_t'(wr_enc);
    end
    if (rd_strobe) begin
      rd_word_q <= rd_mem;   // Raw word, parity untouched
      rd_ecc_q  <= ecc_req;  // Travels with its word
    end
  end

  assign wr_mem = wr_mem_q;

  assign rd_cap = '{word: rd_word_q, ecc: rd_ecc_q, valid: rd_valid_q};

  // Read and write share the memory bus, one direction per cycle
  a_strobe_excl : assert property (
    @(posedge clk) disable iff (!arst_n)
    !(wr_strobe && rd_strobe)
  ) else $error("wr_strobe and rd_strobe high together");

endmodule

`default_nettype wire

/* design/parity_ctrl.sv */
/*
  I/O control register of the parity slice. A control strobe loads the
  parity-disable bit and can fire a one-cycle clear of the sticky errors.
*/
`timescale 1ns/1ps
`default_nettype none

module parity_ctrl (
  input  wire                  clk,
  input  wire                  arst_n,
  input  wire                  ctrl_strobe,  // Single-cycle I/O write
  input  wire mem_parity_pkg::lbd_t ctrl_data,
  output logic                 parity_dis,   // Checking off while set
  output logic                 clr_pulse     // Clear sticky errors
);

  logic dis_bit;  // Disable bit of this write
  logic clr_req;  // Clear requested by this write

  assign dis_bit = ctrl_data[mem_parity_pkg::CTRL_DIS_BIT];
  assign clr_req = ctrl_strobe & ctrl_data[mem_parity_pkg::CTRL_CLR_BIT];

  // Disable bit holds its value between control writes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      parity_dis <= 1'b0;  // Checking on out of reset
    end else if (ctrl_strobe) begin
      parity_dis <= dis_bit;
    end
  end

  // Clear command becomes a registered pulse
  // Back-to-back clear writes merge, the pulse never runs two cycles
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clr_pulse <= 1'b0;
    end else begin
      clr_pulse <= clr_req & ~clr_pulse;
    end
  end

  // Error latch expects a strictly single-cycle clear
  a_clr_single : assert property (
    @(posedge clk) disable iff (!arst_n)
    clr_pulse |=> !clr_pulse
  ) else $error("clr_pulse held high for two cycles");

endmodule

`default_nettype wire

/* design/mem_parity_pkg.sv */
/*
  Shared widths, control bit positions and bus word types for the memory data
  and parity transceiver slice. Modules refer to these by scoped names only.
*/
`default_nettype none

package mem_parity_pkg;

  // Bus and lane widths
  localparam int BYTE_W    = 8;   // One parity bit per lane
  localparam int DATA_W    = 16;  // Local bus word
  localparam int MEM_W     = 18;  // Data plus two parity bits
  localparam int ERR_CNT_W = 8;   // Saturating error counter

  // Control word bit positions, written over the I/O strobe
  localparam int CTRL_DIS_BIT = 0;  // 1 = parity checking off
  localparam int CTRL_CLR_BIT = 1;  // 1 = clear sticky errors

  // Local bus data word
  typedef logic [DATA_W-1:0] lbd_t;

  // Memory word as it sits on the DD bus, parity above each lane
  typedef struct packed {
    logic              par_hi;   // Bit 17
    logic [BYTE_W-1:0] data_hi;  // Bits 16..9
    logic              par_lo;   // Bit 8
    logic [BYTE_W-1:0] data_lo;  // Bits 7..0
  } mem_word_t;

  // Stage 1 read capture
  typedef struct packed {
    mem_word_t word;  // Raw memory word
    logic      ecc;   // Read owned by ECC logic
    logic      valid;
  } rd_cap_t;

  // Stage 2 check result
  typedef struct packed {
    lbd_t data;    // Data with parity stripped
    logic lo_err;  // Low lane parity fault
    logic hi_err;  // High lane parity fault
    logic valid;
  } chk_result_t;

  // Bit that makes the total count of ones, byte plus bit, odd
  function automatic logic odd_parity(input logic [BYTE_W-1:0] b);
    return ~(^b);  // Even count in byte -> 1
  endfunction

endpackage

`default_nettype wire
